// ==== flist.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/hazard_if.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/hazard_forward_unit.sv
logic/halt_controller.sv
logic/rv_core.sv
verification/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f flist.f -o rv_core_sim

output=$(./obj_dir/rv_core_sim)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== verification/rv_core_tb.sv ====
`default_nettype none
`include "rv_cfg.svh"

module rv_core_tb;
  localparam int STALL_MARGIN  = 2;  // run cycles allowed per instruction
  localparam int TEST_OVERHEAD = 64; // reset, idle wait, drain, readback

  logic        clk;
  logic        reset;
  logic        start;
  logic        imem_we;
  logic [5:0]  imem_addr;
  logic [31:0] imem_wdata;
  logic [4:0]  dbg_reg_addr;
  logic [31:0] dbg_reg_data;
  logic        halted;

  logic [31:0] prog [$];                // program under test with word 0 first
  logic [31:0] ref_regs [32];           // reference model state
  logic [31:0] ref_mem [`RV_DMEM_WORDS];
  logic [15:0] lfsr;
  int          checks;
  int          failures;
  int          programs_run;
  int          budget_cycles = 16;      // grows as each program is built

  rv_core rv_core_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data),
    .halted       (halted)
  );

  always #10 clk = ~clk;

  // 16-bit fibonacci with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [11:0] lfsr_imm12();
    logic [11:0] v;
    int          k;
    for (k = 0; k < 12; k++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v[k] = lfsr[0];
    end
    lfsr_imm12 = v;
  endfunction

  // rv32i encoders
  task automatic emit_r(input string op, input int rd, input int rs1, input int rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    case (op)
      "xor":   f3 = 3'b100;
      "or":    f3 = 3'b110;
      "and":   f3 = 3'b111;
      default: f3 = 3'b000; // add and sub
    endcase
    f7 = (op == "sub") ? 7'b0100000 : 7'b0000000;
    prog.push_back({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
  endtask

  task automatic emit_addi(input int rd, input int rs1, input logic [11:0] imm);
    prog.push_back({imm, 5'(rs1), 3'b000, 5'(rd), 7'b0010011});
  endtask

  task automatic emit_lw(input int rd, input int rs1, input logic [11:0] imm);
    prog.push_back({imm, 5'(rs1), 3'b010, 5'(rd), 7'b0000011});
  endtask

  task automatic emit_sw(input int rs2, input int rs1, input logic [11:0] imm);
    prog.push_back({imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011});
  endtask

  task automatic emit_ecall();
    prog.push_back(32'h0000_0073);
  endtask

  task automatic emit_halt();
    emit_addi(17, 0, 12'd10); // a7 = exit code
    emit_ecall();
  endtask

  // sequential ISA model stepping one instruction at a time
  task automatic model_program();
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] res;
    logic [4:0]  rd;
    bit          wr;
    bit          done;
    int          idx;
    ref_regs = '{default: '0};
    ref_mem  = '{default: '0};
    done = 0;
    idx  = 0;
    while (!done && idx < prog.size()) begin
      inst  = prog[idx];
      rd    = inst[11:7];
      a     = ref_regs[inst[19:15]];
      b     = ref_regs[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      wr    = 1;
      res   = '0;
      case (inst[6:0])
        7'b0110011: begin
          case (inst[14:12])
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: res = inst[30] ? a - b : a + b;
          endcase
        end
        7'b0010011: res = a + imm_i;
        7'b0000011: res = ref_mem[6'((a + imm_i) >> 2)];
        7'b0100011: begin
          ref_mem[6'((a + imm_s) >> 2)] = b;
          wr = 0;
        end
        default: begin // ecall
          wr   = 0;
          done = (ref_regs[17] == `RV_HALT_CODE);
        end
      endcase
      if (wr && rd != 0)
        ref_regs[rd] = res;
      idx++;
    end
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      failures++;
      $display("CHECK FAILED %s %s expected %h actual %h", name, what, expected, actual);
    end
  endtask

  task automatic reset_core();
    @(negedge clk);
    reset   = 1'b1;
    start   = 1'b0;
    imem_we = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic load_program();
    int i;
    for (i = 0; i < prog.size(); i++) begin
      imem_we    = 1'b1;
      imem_addr  = 6'(i);
      imem_wdata = prog[i];
      @(negedge clk); // written on the posedge between
    end
    imem_we = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  // reset, load, start, wait for halted, then compare every register
  task automatic run_program(input string name, input bit idle_check, input bit extra_start);
    int fails_before;
    int r;
    fails_before  = failures;
    budget_cycles += prog.size() * (1 + STALL_MARGIN) + TEST_OVERHEAD;
    reset_core();
    check_value(name, "halted after reset", 32'd0, 32'(halted));
    load_program();
    if (idle_check) begin
      repeat (8) @(negedge clk); // no start yet so the core must sit idle
      check_value(name, "halted while idle", 32'd0, 32'(halted));
      dbg_reg_addr = 5'd17;
      #1;
      check_value(name, "x17 while idle", 32'd0, dbg_reg_data);
      @(negedge clk);
    end
    pulse_start();
    if (extra_start) begin
      repeat (3) @(negedge clk);
      pulse_start(); // mid-run strobe that the core ignores
    end
    while (!halted)
      @(negedge clk);
    model_program();
    for (r = 0; r < 32; r++) begin
      @(negedge clk);
      dbg_reg_addr = 5'(r);
      #1;
      check_value(name, $sformatf("x%0d", r), ref_regs[r], dbg_reg_data);
    end
    programs_run++;
    $display("%s finished, %0d failures", name, failures - fails_before);
  endtask

  task automatic dependent_alu_test();
    prog.delete();
    emit_addi(1, 0, lfsr_imm12());
    emit_addi(2, 1, lfsr_imm12()); // x1 from mem stage
    emit_addi(3, 0, lfsr_imm12());
    emit_r("add", 4, 1, 2);        // x2 from wb stage
    emit_r("sub", 5, 4, 3);
    emit_r("and", 6, 5, 4);        // both operands forwarded
    emit_r("or", 7, 6, 5);
    emit_r("xor", 8, 7, 6);
    emit_addi(9, 8, lfsr_imm12());
    emit_r("sub", 10, 9, 8);
    emit_r("xor", 11, 10, 1);
    emit_halt();
    run_program("dependent_alu", 0, 0);
  endtask

  task automatic load_store_test();
    prog.delete();
    emit_addi(1, 0, 12'd16);       // base address
    emit_addi(2, 0, lfsr_imm12());
    emit_sw(2, 1, 12'd0);          // store data forwarded
    emit_lw(3, 1, 12'd0);
    emit_r("add", 4, 3, 2);        // load-use stall
    emit_addi(5, 0, lfsr_imm12());
    emit_sw(5, 1, 12'd4);
    emit_lw(6, 1, 12'd4);
    emit_r("add", 7, 6, 6);
    emit_lw(8, 1, 12'd0);
    emit_addi(9, 0, 12'd1);
    emit_r("add", 10, 8, 9);       // load two back needs no stall
    emit_sw(10, 1, 12'd8);
    emit_lw(11, 1, 12'd8);
    emit_r("sub", 12, 11, 4);
    emit_halt();
    run_program("load_store", 0, 0);
  endtask

  task automatic zero_reg_test();
    prog.delete();
    emit_addi(0, 0, lfsr_imm12()); // dropped write
    emit_r("add", 1, 0, 0);
    emit_addi(0, 0, 12'd5);
    emit_addi(2, 0, 12'd7);        // x0 right after a write to it
    emit_r("xor", 0, 2, 2);
    emit_r("or", 3, 0, 2);
    emit_sw(2, 0, 12'd0);
    emit_lw(0, 0, 12'd0);
    emit_r("add", 4, 0, 2);        // load into x0 must not feed
    emit_halt();
    run_program("zero_reg", 0, 0);
  endtask

  task automatic ecall_test();
    prog.delete();
    emit_addi(17, 0, 12'd5);
    emit_ecall();                  // a7 != 10 makes it a plain no-op
    emit_addi(1, 0, lfsr_imm12());
    emit_addi(17, 0, 12'd11);
    emit_ecall();
    emit_r("add", 2, 1, 1);
    emit_halt();
    emit_addi(3, 0, lfsr_imm12()); // past the halt and never retire
    emit_addi(4, 0, 12'd1);
    emit_r("add", 5, 3, 4);
    run_program("ecall_noop", 0, 0);
  endtask

  task automatic restart_test();
    prog.delete();
    emit_addi(1, 1, lfsr_imm12()); // accumulates so a restart would show
    emit_addi(2, 0, lfsr_imm12());
    emit_r("add", 3, 1, 2);
    emit_r("xor", 4, 3, 1);
    emit_r("sub", 5, 4, 2);
    emit_r("and", 6, 5, 3);
    emit_r("or", 7, 6, 4);
    emit_addi(8, 7, lfsr_imm12());
    emit_halt();
    run_program("restart_first", 1, 1);
    prog.delete();                 // shorter so stale words stay in imem
    emit_addi(9, 0, lfsr_imm12());
    emit_r("sub", 10, 9, 9);
    emit_r("or", 11, 9, 10);
    emit_halt();
    run_program("restart_second", 0, 0);
  endtask

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < budget_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog expired after %0d cycles, core never reached halted", cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_wdata   = '0;
    dbg_reg_addr = '0;
    lfsr         = 16'd12;
    checks       = 0;
    failures     = 0;
    programs_run = 0;
    dependent_alu_test();
    load_store_test();
    zero_reg_test();
    ecall_test();
    restart_test();
    $display("summary: %0d programs, %0d checks, %0d failures", programs_run, checks, failures);
    if (failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`default_nettype none
`include "rv_cfg.svh"

module rv_core import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,      // one-cycle strobe
  input  logic                              imem_we,
  input  logic [$clog2(`RV_IMEM_WORDS)-1:0] imem_addr,  // word index
  input  logic [`RV_XLEN-1:0]               imem_wdata,
  input  logic [$clog2(`RV_REGS)-1:0]       dbg_reg_addr,
  output logic [`RV_XLEN-1:0]               dbg_reg_data,
  output logic                              halted
);
  localparam int    IMEM_AW   = $clog2(`RV_IMEM_WORDS);
  localparam int    DMEM_AW   = $clog2(`RV_DMEM_WORDS);
  localparam word_t HALT_CODE = word_t'(`RV_HALT_CODE);

  word_t      imem [`RV_IMEM_WORDS];
  word_t      dmem [`RV_DMEM_WORDS];
  word_t      pc;          // byte address
  word_t      fetch_inst;
  word_t      if_id_inst;  // all zero is a bubble
  ctrl_t      id_ctrl;
  word_t      id_imm;
  reg_idx_t   id_rs1;
  reg_idx_t   id_rs2;
  reg_idx_t   id_rd;
  word_t      id_rs1_data;
  word_t      id_rs2_data;
  id_ex_t     id_ex;
  ex_mem_t    ex_mem;
  mem_wb_t    mem_wb;
  word_t      op_a;
  word_t      rs2_fwd;     // forwarded rs2, also store data
  word_t      op_b;
  word_t      alu_out;
  word_t      load_data;
  word_t      wb_data;
  logic       stall;
  logic       flush;
  logic       fetch_en;
  logic       halt_req;
  run_state_t state;

  hazard_if hz ();

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      FWD_MEM: fwd_mux = mem_val;
      FWD_WB:  fwd_mux = wb_val;
      default: fwd_mux = reg_val;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (imem_we && state == ST_IDLE) // loader only while idle
      imem[imem_addr] <= imem_wdata;
  end

  assign fetch_inst = imem[pc[IMEM_AW+1:2]];

  always_ff @(posedge clk) begin
    if (reset)
      pc <= '0;
    else if (fetch_en && !stall)
      pc <= pc + word_t'(4);
  end

  always_ff @(posedge clk) begin
    if (reset || flush || !fetch_en)
      if_id_inst <= '0;
    else if (!stall) // hold on load-use
      if_id_inst <= fetch_inst;
  end

  decode_unit decode_unit_i (
    .inst (if_id_inst),
    .ctrl (id_ctrl),
    .imm  (id_imm),
    .rs1  (id_rs1),
    .rs2  (id_rs2),
    .rd   (id_rd)
  );

  reg_file reg_file_i (
    .clk       (clk),
    .reset     (reset),
    .rs1       (id_rs1),
    .rs2       (id_rs2),
    .rd        (mem_wb.rd),
    .rd_data   (wb_data),
    .reg_write (mem_wb.ctrl.reg_write),
    .dbg_addr  (dbg_reg_addr),
    .rs1_data  (id_rs1_data),
    .rs2_data  (id_rs2_data),
    .dbg_data  (dbg_reg_data)
  );

  assign hz.id_rs1        = id_rs1;
  assign hz.id_rs2        = id_rs2;
  assign hz.ex_rs1        = id_ex.rs1;
  assign hz.ex_rs2        = id_ex.rs2;
  assign hz.ex_rd         = id_ex.rd;
  assign hz.ex_mem_read   = id_ex.ctrl.mem_read;
  assign hz.mem_rd        = ex_mem.rd;
  assign hz.mem_reg_write = ex_mem.ctrl.reg_write;
  assign hz.wb_rd         = mem_wb.rd;
  assign hz.wb_reg_write  = mem_wb.ctrl.reg_write;
  assign stall            = hz.stall;

  hazard_forward_unit hazard_forward_unit_i (
    .clk (clk),
    .hz  (hz)
  );

  halt_controller halt_controller_i (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .halt_req (halt_req),
    .fetch_en (fetch_en),
    .flush    (flush),
    .halted   (halted),
    .state    (state)
  );

  always_ff @(posedge clk) begin
    id_ex.rs1_data <= id_rs1_data;
    id_ex.rs2_data <= id_rs2_data;
    id_ex.imm      <= id_imm;
    id_ex.rs1      <= id_rs1;
    id_ex.rs2      <= id_rs2;
    id_ex.rd       <= id_rd;
    if (reset || flush || stall)
      id_ex.ctrl <= '0; // bubble
    else
      id_ex.ctrl <= id_ctrl;
  end

  assign op_a    = fwd_mux(hz.fwd_a, id_ex.rs1_data, ex_mem.alu_out, wb_data);
  assign rs2_fwd = fwd_mux(hz.fwd_b, id_ex.rs2_data, ex_mem.alu_out, wb_data);
  assign op_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_fwd;

  always_comb begin
    case (id_ex.ctrl.alu_fn)
      ALU_SUB: alu_out = op_a - op_b;
      ALU_AND: alu_out = op_a & op_b;
      ALU_OR:  alu_out = op_a | op_b;
      ALU_XOR: alu_out = op_a ^ op_b;
      default: alu_out = op_a + op_b;
    endcase
  end

  // ecall carries a7 as rs1 so op_a is the forwarded a7
  assign halt_req = id_ex.ctrl.is_ecall && (op_a == HALT_CODE);

  always_ff @(posedge clk) begin
    ex_mem.alu_out    <= alu_out;
    ex_mem.store_data <= rs2_fwd;
    ex_mem.rd         <= id_ex.rd;
    if (reset)
      ex_mem.ctrl <= '0;
    else
      ex_mem.ctrl <= id_ex.ctrl;
  end

  always_ff @(posedge clk) begin
    if (ex_mem.ctrl.mem_write)
      dmem[ex_mem.alu_out[DMEM_AW+1:2]] <= ex_mem.store_data;
  end

  assign load_data = dmem[ex_mem.alu_out[DMEM_AW+1:2]]; // async read

  always_ff @(posedge clk) begin
    mem_wb.alu_out   <= ex_mem.alu_out;
    mem_wb.load_data <= load_data;
    mem_wb.rd        <= ex_mem.rd;
    if (reset)
      mem_wb.ctrl <= '0;
    else
      mem_wb.ctrl <= ex_mem.ctrl;
  end

  assign wb_data = mem_wb.ctrl.mem_read ? mem_wb.load_data : mem_wb.alu_out;

  // drain length must cover every older writeback
  no_wb_when_halted: assert property (@(posedge clk) disable iff (reset)
    halted |-> !mem_wb.ctrl.reg_write)
    else $error("writeback after halted");

endmodule

`default_nettype wire

// ==== logic/halt_controller.sv ====
`default_nettype none
`include "rv_cfg.svh"

module halt_controller import rv_pipe_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,    // only looked at in idle
  input  logic       halt_req, // halting ecall in execute
  output logic       fetch_en,
  output logic       flush,
  output logic       halted,
  output run_state_t state
);
  localparam logic [1:0] DRAIN_LOAD = 2'(`RV_DRAIN_CYCLES);

  logic [1:0] drain_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      drain_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: if (start) state <= ST_RUN;
        ST_RUN: if (halt_req) begin
          state     <= ST_DRAIN;
          drain_cnt <= DRAIN_LOAD;
        end
        ST_DRAIN: begin
          if (drain_cnt == 2'd1)
            state <= ST_HALTED; // older instrs all written back
          else
            drain_cnt <= drain_cnt - 2'd1;
        end
        ST_HALTED: ; // sticky until reset
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign fetch_en = (state == ST_RUN);
  assign flush    = fetch_en && halt_req; // kill if/id and id/ex on the halt edge
  assign halted   = (state == ST_HALTED);

  halted_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else $error("halted fell without reset");

endmodule

`default_nettype wire

// ==== logic/hazard_forward_unit.sv ====
`default_nettype none

module hazard_forward_unit import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input logic   clk,
  hazard_if.unit hz
);

  // mem stage wins over wb, x0 never forwards
  function automatic fwd_sel_t pick(input reg_idx_t rs,
                                    input reg_idx_t mem_rd, input logic mem_we,
                                    input reg_idx_t wb_rd, input logic wb_we);
    if (mem_we && mem_rd != '0 && mem_rd == rs)
      pick = FWD_MEM;
    else if (wb_we && wb_rd != '0 && wb_rd == rs)
      pick = FWD_WB;
    else
      pick = FWD_REG;
  endfunction

  assign hz.fwd_a = pick(hz.ex_rs1, hz.mem_rd, hz.mem_reg_write, hz.wb_rd, hz.wb_reg_write);
  assign hz.fwd_b = pick(hz.ex_rs2, hz.mem_rd, hz.mem_reg_write, hz.wb_rd, hz.wb_reg_write);

  // load in execute feeding decode needs one bubble
  assign hz.stall = hz.ex_mem_read && (hz.ex_rd != '0) &&
                    (hz.ex_rd == hz.id_rs1 || hz.ex_rd == hz.id_rs2);

  // the bubble clears ex_mem_read so stall drops the next cycle
  single_bubble: assert property (@(posedge clk) hz.stall |=> !hz.stall)
    else $error("load-use stall held for two cycles");

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none
`include "rv_cfg.svh"

module reg_file import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  input  logic     reg_write,
  input  reg_idx_t dbg_addr,
  output word_t    rs1_data,
  output word_t    rs2_data,
  output word_t    dbg_data
);
  word_t regs [`RV_REGS];
  logic  wr_live; // real write, x0 excluded

  assign wr_live = reg_write && (rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_REGS; i++)
        regs[i] <= '0;
    end else if (wr_live) begin
      regs[rd] <= rd_data;
    end
  end

  // writeback seen by decode in the same cycle
  assign rs1_data = (wr_live && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (wr_live && rd == rs2) ? rd_data : regs[rs2];
  assign dbg_data = regs[dbg_addr]; // no bypass here

  // both read ports, bypass included
  x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    ((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0)))
    else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// ==== logic/decode_unit.sv ====
`default_nettype none
`include "rv_cfg.svh"

module decode_unit import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input  word_t    inst,
  output ctrl_t    ctrl,
  output word_t    imm,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd
);
  logic [2:0] f3;
  logic [6:0] f7;
  word_t      imm_i;
  word_t      imm_s;
  alu_fn_t    r_fn;
  logic       r_ok; // legal R-type funct pair

  assign f3    = inst[14:12];
  assign f7    = inst[31:25];
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]}; // split store offset

  always_comb begin
    r_ok = 1'b1;
    r_fn = ALU_ADD;
    case ({f7, f3})
      {F7_BASE, F3_ADD_SUB}: r_fn = ALU_ADD;
      {F7_SUB, F3_ADD_SUB}:  r_fn = ALU_SUB;
      {F7_BASE, F3_AND}:     r_fn = ALU_AND;
      {F7_BASE, F3_OR}:      r_fn = ALU_OR;
      {F7_BASE, F3_XOR}:     r_fn = ALU_XOR;
      default:               r_ok = 1'b0; // outside the subset
    endcase
  end

  // anything unsupported decodes as a bubble with all register numbers 0
  always_comb begin
    ctrl = '0;
    imm  = '0;
    rs1  = '0;
    rs2  = '0;
    rd   = '0;
    case (opcode_t'(inst[6:0]))
      OP_R: if (r_ok) begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_fn    = r_fn;
        rs1 = inst[19:15];
        rs2 = inst[24:20];
        rd  = inst[11:7];
      end
      OP_IMM: if (f3 == F3_ADD_SUB) begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm = imm_i;
        rs1 = inst[19:15];
        rd  = inst[11:7];
      end
      OP_LOAD: if (f3 == F3_LW) begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1; // base + offset
        imm = imm_i;
        rs1 = inst[19:15];
        rd  = inst[11:7];
      end
      OP_STORE: if (f3 == F3_SW) begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm = imm_s;
        rs1 = inst[19:15];
        rs2 = inst[24:20]; // store data
      end
      OP_SYSTEM: if (inst[31:7] == '0) begin
        ctrl.is_ecall = 1'b1;
        rs1 = reg_idx_t'(17); // a7 rides the normal read and forward paths
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/hazard_if.sv ====
`default_nettype none

// register numbers of the pipe stages out, stall and forward selects back
interface hazard_if import rv_isa_pkg::*, rv_pipe_pkg::*; ();
  reg_idx_t id_rs1;        // decode sources
  reg_idx_t id_rs2;
  reg_idx_t ex_rs1;        // execute sources, forward targets
  reg_idx_t ex_rs2;
  reg_idx_t ex_rd;
  logic     ex_mem_read;   // load sitting in execute
  reg_idx_t mem_rd;
  logic     mem_reg_write;
  reg_idx_t wb_rd;
  logic     wb_reg_write;
  logic     stall;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;

  modport core (
    output id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
    output mem_rd, mem_reg_write, wb_rd, wb_reg_write,
    input  stall, fwd_a, fwd_b
  );

  modport unit (
    input  id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
    input  mem_rd, mem_reg_write, wb_rd, wb_reg_write,
    output stall, fwd_a, fwd_b
  );
endinterface

`default_nettype wire

// ==== logic/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;
  import rv_isa_pkg::*;

  // per-instruction control, travels down the pipe
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;    // lw, also selects wb source
    logic    mem_write;
    logic    alu_src_imm; // operand b from imm
    logic    is_ecall;
    alu_fn_t alu_fn;
  } ctrl_t;

  // execute operand source
  typedef enum logic [1:0] {FWD_REG = 2'b00, FWD_MEM = 2'b01, FWD_WB = 2'b10} fwd_sel_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_out;    // result or mem address
    word_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_out;
    word_t    load_data;
    reg_idx_t rd;
  } mem_wb_t;

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN, ST_HALTED} run_state_t;

endpackage

`default_nettype wire

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none
`include "rv_cfg.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RV_REGS)-1:0] reg_idx_t; // x0..x31

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011, // add sub and or xor
    OP_IMM    = 7'b0010011, // addi
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_SYSTEM = 7'b1110011  // ecall only
  } opcode_t;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_fn_t;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010; // word access only
  localparam logic [2:0] F3_SW      = 3'b010;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000; // bit 30 picks sub

endpackage

`default_nettype wire

// ==== logic/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath word and architectural register count
`define RV_XLEN 32
`define RV_REGS 32

// on-chip memory depths in words
`define RV_IMEM_WORDS 64
`define RV_DMEM_WORDS 64

// a7 value that turns ecall into a halt
`define RV_HALT_CODE 10
`define RV_DRAIN_CYCLES 3 // cycles to empty mem and wb after the halt

`endif
